//--- rtl/fpacc_cfg.svh
`ifndef FPACC_CFG_SVH
`define FPACC_CFG_SVH

// Single-precision fields
`define FPACC_EXP_W 8
`define FPACC_MAN_W 23

// Sign + 2^8 + 23 - 1 bits, LSB weighs 2^-149
`define FPACC_ACC_W 279
`define FPACC_CNT_W 9
`define FPACC_DLY_W 32

// APB register map
`define FPACC_APB_AW 4
`define FPACC_APB_DW 32
`define FPACC_ADDR_CTRL 4'h0
`define FPACC_ADDR_DELAY 4'h4
`define FPACC_ADDR_RESULT 4'h8

// Register reset values
`define FPACC_RST_RUNNING 1'b0
`define FPACC_RST_DELAY 32'd0

`endif

//--- rtl/fpacc_pkg.sv
`include "fpacc_cfg.svh"

package fpacc_pkg;

   typedef struct packed {
      logic                    sign;
      logic [`FPACC_EXP_W-1:0] exp;
      logic [`FPACC_MAN_W-1:0] man;
   } float32_t;

   // Exact two's-complement image of any normal single
   typedef logic signed [`FPACC_ACC_W-1:0] fixed_t;

   typedef struct packed {
      logic                    run;
      logic                    running;
      logic [`FPACC_DLY_W-1:0] delay;
   } accum_cfg_t;

   typedef struct packed {
      logic                     psel;
      logic                     penable;
      logic                     pwrite;
      logic [`FPACC_APB_AW-1:0] paddr;
      logic [`FPACC_APB_DW-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [`FPACC_APB_DW-1:0] prdata;
      logic                     pready;
      logic                     pslverr;
   } apb_rsp_t;

endpackage

//--- rtl/float_to_fixed.sv
`timescale 1ns/1ps
`include "fpacc_cfg.svh"

module float_to_fixed import fpacc_pkg::*; (
   input  float32_t value,
   output fixed_t   fixed
);

   localparam int ACC_W = `FPACC_ACC_W;
   localparam int MAN_W = `FPACC_MAN_W;

   logic [MAN_W:0]   sig;
   logic [ACC_W-1:0] mag;

   // Hidden one in front of the fraction
   assign sig = {1'b1, value.man};

   // Exponent field e puts the hidden bit at position e + 22
   always_comb begin
      mag = '0;
      if (value.exp != '0) begin
         mag = ACC_W'(sig) << (value.exp - 1'b1);
      end
   end

   // Denormals and zero already give mag of 0
   assign fixed = value.sign ? -mag : mag;

endmodule

//--- rtl/lzc.sv
`timescale 1ns/1ps
`include "fpacc_cfg.svh"

module lzc #(
   parameter int WIDTH = 32
) (
   input  logic [WIDTH-1:0]        data,
   output logic [`FPACC_CNT_W-1:0] count
);

   localparam int CNT_W = `FPACC_CNT_W;

   // Scan from the MSB, first one found wins
   always_comb begin
      logic found;
      found = 1'b0;
      count = CNT_W'(WIDTH);
      for (int i = WIDTH - 1; i >= 0; i--) begin
         if (data[i] && !found) begin
            count = CNT_W'(WIDTH - 1 - i);
            found = 1'b1;
         end
      end
   end

endmodule

//--- rtl/float_accum.sv
`timescale 1ns/1ps
`include "fpacc_cfg.svh"

module float_accum import fpacc_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  accum_cfg_t cfg,
   input  float32_t   value,
   input  logic       restart,
   output float32_t   result
);

   localparam int ACC_W = `FPACC_ACC_W;
   localparam int MAG_W = ACC_W - 1;
   localparam int EXP_W = `FPACC_EXP_W;
   localparam int MAN_W = `FPACC_MAN_W;
   localparam int CNT_W = `FPACC_CNT_W;
   localparam logic [CNT_W-1:0] EXP_TOP = CNT_W'((1 << EXP_W) - 1);

   logic [`FPACC_DLY_W-1:0] dly_cnt;
   logic                    start;

   fixed_t     dec_fixed;
   fixed_t     dec_q;
   fixed_t     acc_q;
   fixed_t     acc_neg;
   logic       acc_sign;
   logic       acc_zero;
   logic       load_new;

   logic [CNT_W-1:0] lz_pos;
   logic [CNT_W-1:0] lz_neg;
   logic [CNT_W-1:0] lz_mag;
   logic [MAG_W-1:0] mag_next;

   logic             sign_q;
   logic [EXP_W-1:0] exp_q;
   logic [CNT_W-1:0] lz_q;
   logic [MAG_W-1:0] mag_q;
   logic [MAG_W-1:0] norm;

   // Restart delay counter, armed by the run pulse
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         dly_cnt <= '0;
         start   <= 1'b0;
      end else if (cfg.run) begin
         dly_cnt <= cfg.delay + 1'b1;
         start   <= 1'b0;
      end else if (dly_cnt != '0) begin
         dly_cnt <= dly_cnt - 1'b1;
         start   <= 1'b1;
      end else begin
         start   <= 1'b0;
      end
   end

   // Stage 1
   float_to_fixed u_decode (
      .value (value),
      .fixed (dec_fixed)
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         dec_q <= '0;
      end else if (cfg.running) begin
         dec_q <= dec_fixed;
      end
   end

   // Stage 2, restart arrives one cycle behind its value
   assign load_new = restart || (start && dly_cnt == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc_q <= '0;
      end else if (load_new) begin
         acc_q <= dec_q;
      end else if (cfg.running) begin
         acc_q <= acc_q + dec_q;
      end
   end

   // Stage 3
   assign acc_neg  = -acc_q;
   assign acc_sign = acc_q[ACC_W-1];
   assign acc_zero = (acc_q == '0);

   lzc #(.WIDTH(MAG_W)) u_lzc_pos (
      .data  (acc_q[MAG_W-1:0]),
      .count (lz_pos)
   );

   lzc #(.WIDTH(MAG_W)) u_lzc_neg (
      .data  (acc_neg[MAG_W-1:0]),
      .count (lz_neg)
   );

   assign lz_mag   = acc_sign ? lz_neg : lz_pos;
   assign mag_next = acc_sign ? acc_neg[MAG_W-1:0] : acc_q[MAG_W-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sign_q <= 1'b0;
         exp_q  <= '0;
         lz_q   <= '0;
         mag_q  <= '0;
      end else if (cfg.running) begin
         sign_q <= acc_sign;
         exp_q  <= acc_zero ? '0 : EXP_W'(EXP_TOP - lz_mag);
         lz_q   <= lz_mag;
         mag_q  <= mag_next;
      end
   end

   // Stage 4, leading one lands on the MSB, fraction truncated
   assign norm = mag_q << lz_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result <= '0;
      end else if (cfg.running) begin
         result.sign <= sign_q;
         result.exp  <= exp_q;
         result.man  <= norm[MAG_W-2 -: MAN_W];
      end
   end

   a_run_pulse : assert property (@(posedge clk) disable iff (rst)
      cfg.run |=> !cfg.run);

   a_no_max_exp : assert property (@(posedge clk) disable iff (rst)
      result.exp != '1);

   // Zero sum reaches the output after two running cycles
   a_zero_sum : assert property (@(posedge clk) disable iff (rst)
      (cfg.running && acc_zero) ##1 cfg.running |=> result == '0);

endmodule

//--- rtl/fpacc_apb_regs.sv
`timescale 1ns/1ps
`include "fpacc_cfg.svh"

module fpacc_apb_regs import fpacc_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  apb_req_t   apb_req,
   output apb_rsp_t   apb_rsp,
   input  float32_t   result,
   output accum_cfg_t cfg
);

   logic                    running_q;
   logic                    run_q;
   logic [`FPACC_DLY_W-1:0] delay_q;

   logic access;
   logic wr;
   logic sel_ctrl;
   logic sel_delay;
   logic sel_result;
   logic mapped;

   // Access phase completes at once, no wait states
   assign access = apb_req.psel && apb_req.penable;
   assign wr     = access && apb_req.pwrite;

   assign sel_ctrl   = (apb_req.paddr == `FPACC_ADDR_CTRL);
   assign sel_delay  = (apb_req.paddr == `FPACC_ADDR_DELAY);
   assign sel_result = (apb_req.paddr == `FPACC_ADDR_RESULT);
   assign mapped     = sel_ctrl || sel_delay || sel_result;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         running_q <= `FPACC_RST_RUNNING;
         delay_q   <= `FPACC_RST_DELAY;
         run_q     <= 1'b0;
      end else begin
         // Run bit is a strobe, live for one cycle after the write
         run_q <= wr && sel_ctrl && apb_req.pwdata[1];
         if (wr && sel_ctrl) begin
            running_q <= apb_req.pwdata[0];
         end
         if (wr && sel_delay) begin
            delay_q <= apb_req.pwdata[`FPACC_DLY_W-1:0];
         end
      end
   end

   // Read mux
   always_comb begin
      apb_rsp.prdata = '0;
      if (sel_ctrl) begin
         apb_rsp.prdata[0] = running_q;
      end else if (sel_delay) begin
         apb_rsp.prdata[`FPACC_DLY_W-1:0] = delay_q;
      end else if (sel_result) begin
         apb_rsp.prdata = result;
      end
   end

   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && sel_result));

   assign cfg.run     = run_q;
   assign cfg.running = running_q;
   assign cfg.delay   = delay_q;

   a_penable_psel : assert property (@(posedge clk) disable iff (rst)
      $rose(apb_req.penable) |-> apb_req.psel);

endmodule

//--- rtl/fpacc_top.sv
`timescale 1ns/1ps

module fpacc_top import fpacc_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  apb_req_t apb_req,
   output apb_rsp_t apb_rsp,
   input  float32_t value,
   input  logic     restart,
   output float32_t result
);

   accum_cfg_t cfg;

   fpacc_apb_regs u_regs (
      .clk     (clk),
      .rst     (rst),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .result  (result),
      .cfg     (cfg)
   );

   // Stream inputs go straight to the datapath
   float_accum u_accum (
      .clk     (clk),
      .rst     (rst),
      .cfg     (cfg),
      .value   (value),
      .restart (restart),
      .result  (result)
   );

endmodule

//--- tb/tb_fpacc_top.sv
`timescale 1ns/1ps
`include "fpacc_cfg.svh"

module tb_fpacc_top import fpacc_pkg::*; ();

   // Roughly twice the cycles that all tests need together
   localparam int TIMEOUT_CYC = 3000;

   logic     clk = 1'b0;
   logic     rst;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;
   float32_t value;
   logic     restart;
   float32_t result;

   int          cyc = 0;
   int          err_stream = 0;
   int          err_apb = 0;
   int          err_prop = 0;
   int          test_errs = 0;
   int          n_pass = 0;
   int          n_fail = 0;
   string       test_name = "reset";
   int          model_sum = 0;
   logic        hold_chk = 1'b0;
   logic [31:0] held_val = '0;

   // Expected results and the cycle in which each must show
   int          due_q[$];
   logic [31:0] want_q[$];

   fpacc_top u_dut (
      .clk     (clk),
      .rst     (rst),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .value   (value),
      .restart (restart),
      .result  (result)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYC) begin
         $display("timeout: tests still running after %0d cycles", cyc);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // Exact single for an integer below 2^24 in magnitude
   function automatic logic [31:0] encode_int(input int n);
      int          mag;
      int          msb;
      logic [31:0] f;
      mag = (n < 0) ? -n : n;
      msb = 0;
      for (int b = 0; b < 24; b++) begin
         if (mag[b]) begin
            msb = b;
         end
      end
      f = '0;
      if (mag != 0) begin
         f[31]    = (n < 0);
         f[30:23] = 8'(127 + msb);
         f[22:0]  = 23'(mag << (23 - msb));
      end
      return f;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'($urandom_range(hi - lo));
   endfunction

   function automatic int total_errs();
      return err_stream + err_apb + err_prop;
   endfunction

   // A value sampled at edge c + 1 reaches result at edge c + 4
   always @(negedge clk) begin
      if (due_q.size() > 0 && due_q[0] == cyc) begin
         a_stream_sum : assert (result === want_q[0]) else begin
            err_stream++;
            $display("error: %s expected %h actual %h", test_name, want_q[0], result);
         end
         void'(due_q.pop_front());
         void'(want_q.pop_front());
      end
   end

   a_hold_result : assert property (@(posedge clk) disable iff (rst)
      hold_chk |-> result == held_val)
      else begin
         err_prop++;
         $display("error: %s expected %h actual %h", test_name, held_val, result);
      end

   // Starts and ends 1 ns after a rising edge
   task automatic apb_access(input logic write, input logic [`FPACC_APB_AW-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;
      @(negedge clk);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      a_pready : assert (apb_rsp.pready === 1'b1) else begin
         err_apb++;
         $display("%s: pready low in the access phase at address %h", test_name, addr);
      end
      @(posedge clk);
      #1;
      apb_req = '0;
   endtask

   task automatic apb_write(input logic [`FPACC_APB_AW-1:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, addr, data, rd, err);
      a_write_ok : assert (err === 1'b0) else begin
         err_apb++;
         $display("%s: write to address %h raised pslverr", test_name, addr);
      end
   endtask

   task automatic apb_read(input logic [`FPACC_APB_AW-1:0] addr, input logic [31:0] want);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b0, addr, '0, rd, err);
      a_read_ok : assert (err === 1'b0) else begin
         err_apb++;
         $display("%s: read from address %h raised pslverr", test_name, addr);
      end
      a_read_data : assert (rd === want) else begin
         err_apb++;
         $display("error: %s expected %h actual %h", test_name, want, rd);
      end
   endtask

   task automatic apb_bad(input logic write, input logic [`FPACC_APB_AW-1:0] addr);
      logic [31:0] rd;
      logic        err;
      apb_access(write, addr, 32'hffff_ffff, rd, err);
      a_slverr : assert (err === 1'b1) else begin
         err_apb++;
         $display("%s: access to address %h gave no pslverr", test_name, addr);
      end
   endtask

   // One value per cycle, the restart strobe for value i rides with value i + 1
   task automatic stream(input int n, input int load_idx, input int restart_pct,
                         input int lo, input int hi, input bit first_new);
      int v;
      bit r;
      bit prev_r;
      prev_r = 1'b0;
      for (int i = 0; i < n; i++) begin
         v = rand_range(lo, hi);
         r = (first_new && i == 0) || (rand_range(0, 99) < restart_pct);
         value     = encode_int(v);
         restart   = prev_r;
         model_sum = (r || i == load_idx) ? v : model_sum + v;
         due_q.push_back(cyc + 4);
         want_q.push_back(encode_int(model_sum));
         prev_r = r;
         @(posedge clk);
         #1;
      end
      value   = '0;
      restart = prev_r;
      @(posedge clk);
      #1;
      restart = 1'b0;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_errs = total_errs();
   endtask

   task automatic end_test();
      while (due_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
      if (total_errs() == test_errs) begin
         n_pass++;
         $display("test %s: ok", test_name);
      end else begin
         n_fail++;
         $display("test %s: %0d errors", test_name, total_errs() - test_errs);
      end
   endtask

   // Run pulse lands 3 cycles after the write starts, so value d + 3 starts the sum
   task automatic delayed_restart(input int d);
      begin_test($sformatf("restart_delay_%0d", d));
      apb_write(`FPACC_ADDR_DELAY, 32'(d));
      fork
         apb_write(`FPACC_ADDR_CTRL, 32'd3);
         stream(d + 8, d + 3, 0, -1000, 1000, 1'b0);
      join
      end_test();
   endtask

   initial begin
      void'($urandom(74));
      rst     = 1'b1;
      apb_req = '0;
      value   = '0;
      restart = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      begin_test("reset");
      a_reset_result : assert (result === '0) else begin
         err_apb++;
         $display("error: %s expected %h actual %h", test_name, 32'h0, result);
      end
      apb_read(`FPACC_ADDR_CTRL, 32'h0);
      apb_read(`FPACC_ADDR_DELAY, 32'h0);
      apb_read(`FPACC_ADDR_RESULT, 32'h0);
      end_test();

      begin_test("apb_access");
      apb_write(`FPACC_ADDR_DELAY, 32'ha5c3_0f96);
      apb_read(`FPACC_ADDR_DELAY, 32'ha5c3_0f96);
      apb_write(`FPACC_ADDR_DELAY, 32'h0);
      apb_write(`FPACC_ADDR_CTRL, 32'h3);
      apb_read(`FPACC_ADDR_CTRL, 32'h1);
      apb_write(`FPACC_ADDR_CTRL, 32'h0);
      apb_read(`FPACC_ADDR_CTRL, 32'h0);
      apb_bad(1'b1, `FPACC_ADDR_RESULT);
      apb_bad(1'b0, 4'hc);
      apb_bad(1'b1, 4'hc);
      end_test();

      begin_test("stream_sum");
      apb_write(`FPACC_ADDR_CTRL, 32'h1);
      stream(1000, -1, 5, -1000, 1000, 1'b0);
      // Negative values only, totals below zero
      stream(300, -1, 10, -1000, -1, 1'b1);
      end_test();

      delayed_restart(0);
      delayed_restart(3);
      delayed_restart(7);

      begin_test("hold");
      held_val = encode_int(model_sum);
      apb_write(`FPACC_ADDR_CTRL, 32'h0);
      hold_chk = 1'b1;
      for (int i = 0; i < 12; i++) begin
         value = encode_int(rand_range(-1000, 1000));
         @(posedge clk);
         #1;
      end
      apb_read(`FPACC_ADDR_RESULT, held_val);
      hold_chk = 1'b0;
      // Last held value stays on the input while running comes back
      apb_write(`FPACC_ADDR_CTRL, 32'h1);
      stream(20, -1, 0, -1000, 1000, 1'b0);
      end_test();

      $display("tests passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0 && total_errs() == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- fp_accum.f
+incdir+rtl
rtl/fpacc_pkg.sv
rtl/float_to_fixed.sv
rtl/lzc.sv
rtl/float_accum.sv
rtl/fpacc_apb_regs.sv
rtl/fpacc_top.sv
tb/tb_fpacc_top.sv

//--- Makefile
TOP   = tb_fpacc_top
FLIST = fp_accum.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf obj_dir
